// File: compile.f
+incdir+verilog
verilog/bench_pkg.sv
verilog/bench_cfg_if.sv
verilog/bench_regs.sv
verilog/bench_engine.sv
verilog/bench_top.sv
verif/tb_clk_gen.sv
verif/tb_bench.sv

// File: verif/tb_bench.sv
/* Benchmark block testbench with AXI4-Lite host tasks, request responder,
   register and request model and checks */

`timescale 1ns/10ps
`default_nettype none

`include "bench_params.svh"

module tb_bench;

  localparam int  NUM_RUNS    = 20;
  localparam int  MAX_REPS    = 64;
  localparam int  CLK_NS      = 40;
  localparam time WATCHDOG_NS = NUM_RUNS * MAX_REPS * 200 * CLK_NS;

  typedef struct packed {
    bench_pkg::vaddr_t vaddr;
    bench_pkg::len_t   len;
    bench_pkg::pid_t   pid;
    logic              write;
  } req_rec_t;

  logic                  aclk;
  logic                  aresetn;
  bench_pkg::axil_addr_t awaddr;
  bench_pkg::axil_addr_t araddr;
  bench_pkg::axil_data_t wdata;
  bench_pkg::axil_data_t rdata;
  bench_pkg::axil_strb_t wstrb;
  logic                  awvalid;
  logic                  awready;
  logic                  wvalid;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;
  logic                  arvalid;
  logic                  arready;
  logic [1:0]            rresp;
  logic                  rvalid;
  logic                  rready;
  logic                  req_valid;
  logic                  req_ready;
  bench_pkg::vaddr_t     req_vaddr;
  bench_pkg::len_t       req_len;
  bench_pkg::pid_t       req_pid;
  logic                  req_write;
  logic                  cmpl_valid;
  logic                  beat_valid;

  bench_pkg::axil_data_t model_reg [`BENCH_N_REGS];   // Config register image
  req_rec_t              req_log [$];   // Requests taken in the current run
  req_rec_t              pending [$];   // Taken but not yet completed
  int                    cmpl_sent = 0;

  tb_clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(4)) i_clk (.aclk(aclk), .aresetn(aresetn));

  bench_top i_dut (.*);

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_data(input string name, input bench_pkg::axil_data_t exp,
                            input bench_pkg::axil_data_t got);
    if (got !== exp) begin
      $display("Error %s expected %h got %h", name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input bench_pkg::reps_t exp,
                             input bench_pkg::reps_t got);
    if (got !== exp) begin
      $display("Error %s expected %h got %h", name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp,
                            input logic [1:0] got);
    if (got !== exp) begin
      $display("Error %s expected %h got %h", name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_req(input int idx, input bench_pkg::vaddr_t exp_vaddr,
                           input bench_pkg::len_t exp_len, input bench_pkg::pid_t exp_pid,
                           input logic exp_write, input req_rec_t got);
    if (got.vaddr !== exp_vaddr || got.len !== exp_len || got.pid !== exp_pid ||
        got.write !== exp_write) begin
      $display("Error req[%0d] vaddr/len/pid/write expected %h/%h/%h/%h got %h/%h/%h/%h",
               idx, exp_vaddr, exp_len, exp_pid, exp_write,
               got.vaddr, got.len, got.pid, got.write);
      abort_run();
    end
  endtask

  // Zero-extended read value of a config register
  function automatic bench_pkg::axil_data_t expected_field(input int idx);
    bench_pkg::axil_data_t w;
    w = model_reg[idx];
    case (idx)
      `BENCH_VADDR_REG:  return w & ((64'd1 << `BENCH_VADDR_BITS) - 1);
      `BENCH_LEN_REG:    return w & ((64'd1 << `BENCH_LEN_BITS) - 1);
      `BENCH_PID_REG:    return w & ((64'd1 << `BENCH_PID_BITS) - 1);
      `BENCH_N_REPS_REG: return w & 64'hffff_ffff;
      default:           return w;
    endcase
  endfunction

  // ------------------------------
  // AXI4-Lite host
  // ------------------------------
  // Called on a falling edge; updates the model for config registers
  task automatic axil_write(input int idx, input bench_pkg::axil_data_t data,
                            input bench_pkg::axil_strb_t strb);
    bench_pkg::axil_data_t mask;
    for (int b = 0; b < 8; b++) begin
      mask[b*8 +: 8] = {8{strb[b]}};
    end
    if (idx >= `BENCH_VADDR_REG) begin
      model_reg[idx] = (model_reg[idx] & ~mask) | (data & mask);
    end
    awaddr  = bench_pkg::axil_addr_t'(idx * 8);
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge aclk);
    while (!awready) @(negedge aclk);
    if (!wready) begin
      $display("Write data was not accepted together with the write address");
      abort_run();
    end
    @(negedge aclk);   // Handshake was on the edge just passed
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (!bvalid) begin
      $display("Write response did not arrive one cycle after the handshake");
      abort_run();
    end
    check_resp("bresp", 2'b00, bresp);
    bready  = 1'b1;
    while (bvalid) @(negedge aclk);
    bready = 1'b0;
  endtask

  task automatic axil_read(input int idx, output bench_pkg::axil_data_t data);
    araddr  = bench_pkg::axil_addr_t'(idx * 8);
    arvalid = 1'b1;
    @(negedge aclk);
    while (!arready) @(negedge aclk);
    @(negedge aclk);
    arvalid = 1'b0;
    if (!rvalid) begin
      $display("Read data did not arrive one cycle after the address handshake");
      abort_run();
    end
    check_resp("rresp", 2'b00, rresp);
    data   = rdata;
    rready = 1'b1;
    while (rvalid) @(negedge aclk);
    rready = 1'b0;
  endtask

  // ------------------------------
  // Request responder
  // ------------------------------
  // Valid seen here with ready set means a transfer on the next rising edge
  always @(negedge aclk) begin
    req_ready = ($urandom_range(0, 3) != 0);
    if (aresetn && req_valid && req_ready) begin
      req_log.push_back('{req_vaddr, req_len, req_pid, req_write});
      pending.push_back('{req_vaddr, req_len, req_pid, req_write});
    end
  end

  initial begin : completion_gen
    req_rec_t rec;
    forever begin
      @(negedge aclk);
      if (pending.size() != 0) begin
        rec = pending.pop_front();
        repeat ($urandom_range(0, 6)) @(negedge aclk);
        repeat ((rec.len + 63) / 64) begin   // One beat per 64 bytes
          beat_valid = 1'b1;
          @(negedge aclk);
          beat_valid = 1'b0;
        end
        cmpl_valid = 1'b1;
        @(negedge aclk);
        cmpl_valid = 1'b0;
        cmpl_sent++;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the test was still running after %0d ns", WATCHDOG_NS);
    abort_run();
  end

  // One benchmark run checked against the model
  task automatic run_bench(input int run);
    bench_pkg::reps_t      n_reps;
    bench_pkg::len_t       len;
    bench_pkg::vaddr_t     vaddr;
    bench_pkg::pid_t       pid;
    bench_pkg::bench_ctrl_t ctrl;
    bench_pkg::axil_data_t rd;
    bench_pkg::axil_data_t t1;
    int                    base;
    n_reps = $urandom_range(0, MAX_REPS);
    len    = $urandom_range(0, 320);
    vaddr  = bench_pkg::vaddr_t'({$urandom, $urandom});
    pid    = bench_pkg::pid_t'($urandom);
    ctrl   = bench_pkg::bench_ctrl_t'($urandom_range(1, 3));
    axil_write(`BENCH_VADDR_REG, vaddr, '1);
    axil_write(`BENCH_LEN_REG, len, '1);
    axil_write(`BENCH_PID_REG, pid, '1);
    axil_write(`BENCH_N_REPS_REG, n_reps, '1);
    axil_write(`BENCH_N_BEATS_REG, n_reps * ((len + 63) / 64), '1);
    req_log.delete();
    base = cmpl_sent;
    axil_write(`BENCH_CTRL_REG, ctrl, '1);
    if (n_reps >= 8 && run % 2 == 1) begin
      axil_write(`BENCH_CTRL_REG, 2'b11, '1);   // Start again while busy
    end
    while (cmpl_sent - base < n_reps) @(negedge aclk);
    repeat (4) @(negedge aclk);
    axil_read(`BENCH_DONE_REG, rd);
    check_count("done", n_reps, bench_pkg::reps_t'(rd));
    axil_read(`BENCH_TIMER_REG, t1);
    if (n_reps != 0 && t1 == 0) begin
      $display("Timer read zero after a run of %0d requests", n_reps);
      abort_run();
    end
    axil_write(`BENCH_DONE_REG, {$urandom, $urandom}, '1);
    axil_write(`BENCH_TIMER_REG, {$urandom, $urandom}, '1);
    axil_read(`BENCH_TIMER_REG, rd);
    check_data("timer", t1, rd);   // Frozen and not writable
    axil_read(`BENCH_DONE_REG, rd);
    check_data("done", bench_pkg::axil_data_t'(n_reps), rd);
    axil_read(`BENCH_CTRL_REG, rd);
    check_data("ctrl", '0, rd);
    check_count("request count", n_reps, req_log.size());
    foreach (req_log[i]) begin
      check_req(i, vaddr + bench_pkg::vaddr_t'(i * len), len, pid, ctrl[1], req_log[i]);
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin : main_seq
    bench_pkg::axil_data_t rd;
    bench_pkg::axil_data_t data;
    bench_pkg::axil_strb_t strb;
    int                    idx;
    void'($urandom(32'h4d78_fb01));
    awaddr     = '0;
    araddr     = '0;
    wdata      = '0;
    wstrb      = '0;
    awvalid    = 1'b0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    req_ready  = 1'b0;
    cmpl_valid = 1'b0;
    beat_valid = 1'b0;
    model_reg  = '{default: '0};
    @(posedge aresetn);
    @(negedge aclk);

    // Strobed config writes, each read back
    repeat (40) begin
      idx  = $urandom_range(`BENCH_VADDR_REG, `BENCH_N_BEATS_REG);
      data = {$urandom, $urandom};
      strb = bench_pkg::axil_strb_t'($urandom);
      axil_write(idx, data, strb);
      axil_read(idx, rd);
      check_data($sformatf("reg%0d", idx), expected_field(idx), rd);
    end

    for (int run = 0; run < NUM_RUNS; run++) begin
      run_bench(run);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
/* Testbench clock and reset source */

`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 4
) (
  output logic aclk,
  output logic aresetn
);

  initial begin
    aclk = 1'b0;
    forever #(PERIOD_NS / 2) aclk = ~aclk;
  end

  initial begin
    aresetn = 1'b0;
    repeat (RST_CYCLES) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;   // Released away from the active edge
  end

endmodule

`default_nettype wire

// File: verilog/bench_top.sv
/* Benchmark block top level joining register slave and request engine */

`timescale 1ns/10ps
`default_nettype none

module bench_top (
  input  logic                   aclk,
  input  logic                   aresetn,

  // AXI4-Lite control slave
  input  bench_pkg::axil_addr_t  awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  bench_pkg::axil_data_t  wdata,
  input  bench_pkg::axil_strb_t  wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output logic [1:0]             bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  bench_pkg::axil_addr_t  araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output bench_pkg::axil_data_t  rdata,
  output logic [1:0]             rresp,
  output logic                   rvalid,
  input  logic                   rready,

  // Requests out and completions back
  output logic                   req_valid,
  input  logic                   req_ready,
  output bench_pkg::vaddr_t      req_vaddr,
  output bench_pkg::len_t        req_len,
  output bench_pkg::pid_t        req_pid,
  output logic                   req_write,
  input  logic                   cmpl_valid,
  input  logic                   beat_valid
);

  bench_cfg_if i_cfg ();

  bench_regs i_regs (
    .aclk    (aclk),
    .aresetn (aresetn),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .cfg     (i_cfg.regs)
  );

  bench_engine i_engine (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .cfg        (i_cfg.engine),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_vaddr  (req_vaddr),
    .req_len    (req_len),
    .req_pid    (req_pid),
    .req_write  (req_write),
    .cmpl_valid (cmpl_valid),
    .beat_valid (beat_valid)
  );

endmodule

`default_nettype wire

// File: verilog/bench_engine.sv
/* Benchmark request engine with issue FSM, completion and beat counters
   and the run timer */

`timescale 1ns/10ps
`default_nettype none

module bench_engine (
  input  logic               aclk,
  input  logic               aresetn,

  bench_cfg_if.engine        cfg,

  // Request channel
  output logic               req_valid,
  input  logic               req_ready,
  output bench_pkg::vaddr_t  req_vaddr,
  output bench_pkg::len_t    req_len,
  output bench_pkg::pid_t    req_pid,
  output logic               req_write,

  // Feedback from the datapath
  input  logic               cmpl_valid,
  input  logic               beat_valid
);

  bench_pkg::eng_state_t state;

  bench_pkg::reps_t  issued;
  bench_pkg::reps_t  done_cnt;
  bench_pkg::reps_t  reps_q;      // Run size latched at start
  bench_pkg::beats_t beats_cnt;
  bench_pkg::beats_t n_beats_q;
  bench_pkg::timer_t timer_q;

  logic start;
  logic req_fire;
  logic last_req;
  logic finished;

  assign start    = (state == bench_pkg::ENG_IDLE) && (cfg.ctrl != '0);
  assign req_fire = req_valid && req_ready;
  assign last_req = (issued + 1'b1) == reps_q;
  assign finished = (state == bench_pkg::ENG_WAIT) &&
                    (done_cnt == reps_q) && (beats_cnt >= n_beats_q);

  assign req_valid = (state == bench_pkg::ENG_ISSUE);

  // ------------------------------
  // Issue FSM
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= bench_pkg::ENG_IDLE;
    end else begin
      case (state)
        bench_pkg::ENG_IDLE: begin
          if (start) begin
            // Empty run goes straight to the drain check
            state <= (cfg.n_reps == '0) ? bench_pkg::ENG_WAIT : bench_pkg::ENG_ISSUE;
          end
        end
        bench_pkg::ENG_ISSUE: begin
          if (req_fire && last_req) begin
            state <= bench_pkg::ENG_WAIT;
          end
        end
        bench_pkg::ENG_WAIT: begin
          if (finished) begin
            state <= bench_pkg::ENG_IDLE;
          end
        end
        default: state <= bench_pkg::ENG_IDLE;
      endcase
    end
  end

  // ------------------------------
  // Counters and timer
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      issued    <= '0;
      done_cnt  <= '0;
      beats_cnt <= '0;
      timer_q   <= '0;
    end else if (start) begin
      issued    <= '0;
      done_cnt  <= '0;
      beats_cnt <= '0;
      timer_q   <= '0;
    end else if (state != bench_pkg::ENG_IDLE) begin
      timer_q <= timer_q + 1'b1;   // Frozen once back in idle
      if (req_fire) begin
        issued <= issued + 1'b1;
      end
      if (cmpl_valid) begin
        done_cnt <= done_cnt + 1'b1;
      end
      if (beat_valid) begin
        beats_cnt <= beats_cnt + 1'b1;
      end
    end
  end

  // Run parameters held for the whole run
  always_ff @(posedge aclk) begin
    if (start) begin
      req_vaddr <= cfg.vaddr;
      req_len   <= cfg.len;
      req_pid   <= cfg.pid;
      req_write <= cfg.ctrl[1];   // Write wins if both bits are set
      reps_q    <= cfg.n_reps;
      n_beats_q <= cfg.n_beats;
    end else if (req_fire) begin
      req_vaddr <= req_vaddr + bench_pkg::vaddr_t'(req_len);
    end
  end

  assign cfg.done  = done_cnt;
  assign cfg.timer = timer_q;

  // Stalled request keeps valid and payload until taken
  a_req_stable : assert property (
    @(posedge aclk) disable iff (!aresetn)
    req_valid && !req_ready |=>
      req_valid && $stable({req_vaddr, req_len, req_pid, req_write})
  ) else $error("request dropped or changed under back-pressure");

endmodule

`default_nettype wire

// File: verilog/bench_regs.sv
/* AXI4-Lite register slave with the benchmark register map
   W1S control, strobed config registers and read-only status */

`timescale 1ns/10ps
`default_nettype none

`include "bench_params.svh"

module bench_regs (
  input  logic                   aclk,
  input  logic                   aresetn,

  // AXI4-Lite write channels
  input  bench_pkg::axil_addr_t  awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  bench_pkg::axil_data_t  wdata,
  input  bench_pkg::axil_strb_t  wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output logic [1:0]             bresp,
  output logic                   bvalid,
  input  logic                   bready,

  // AXI4-Lite read channels
  input  bench_pkg::axil_addr_t  araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output bench_pkg::axil_data_t  rdata,
  output logic [1:0]             rresp,
  output logic                   rvalid,
  input  logic                   rready,

  bench_cfg_if.regs              cfg
);

  localparam int STRB_BITS = `BENCH_AXIL_DATA_BITS / 8;
  localparam int ADDR_LSB  = $clog2(STRB_BITS);       // Byte offset within a word
  localparam int IDX_BITS  = $clog2(`BENCH_N_REGS);

  bench_pkg::axil_data_t slv_reg [`BENCH_N_REGS];

  logic [IDX_BITS-1:0] wr_idx;
  logic [IDX_BITS-1:0] rd_idx;
  logic                wr_ready;   // Shared by aw and w
  logic                wr_start;
  logic                wr_en;
  logic                rd_start;
  logic                rd_en;

  // Byte lanes of new_word replace those of old_word where strb is set
  function automatic bench_pkg::axil_data_t strb_merge(
    input bench_pkg::axil_data_t old_word,
    input bench_pkg::axil_data_t new_word,
    input bench_pkg::axil_strb_t strb
  );
    bench_pkg::axil_data_t res;
    res = old_word;
    for (int i = 0; i < STRB_BITS; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return res;
  endfunction

  // ------------------------------
  // Handshakes
  // ------------------------------
  assign wr_start = !wr_ready && !bvalid && awvalid && wvalid;
  assign wr_en    = wr_ready && awvalid && wvalid;
  assign rd_start = !arready && !rvalid && arvalid;
  assign rd_en    = arready && arvalid;

  assign awready = wr_ready;
  assign wready  = wr_ready;
  assign bresp   = 2'b00;   // Always OKAY
  assign rresp   = 2'b00;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ready <= 1'b0;
      bvalid   <= 1'b0;
      arready  <= 1'b0;
      rvalid   <= 1'b0;
    end else begin
      wr_ready <= wr_start;   // Single-cycle ready pulse
      arready  <= rd_start;

      if (wr_en) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end

      if (rd_en) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Word index captured as the handshake opens
  always_ff @(posedge aclk) begin
    if (wr_start) begin
      wr_idx <= awaddr[ADDR_LSB +: IDX_BITS];
    end
    if (rd_start) begin
      rd_idx <= araddr[ADDR_LSB +: IDX_BITS];
    end
  end

  // ------------------------------
  // Register writes
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      slv_reg <= '{default: '0};
    end else begin
      slv_reg[`BENCH_CTRL_REG] <= '0;   // Start bits last one cycle

      if (wr_en) begin
        case (wr_idx)
          `BENCH_DONE_REG, `BENCH_TIMER_REG: ;   // Status owned by the engine
          default: slv_reg[wr_idx] <= strb_merge(slv_reg[wr_idx], wdata, wstrb);
        endcase
      end
    end
  end

  // Fields handed to the engine
  assign cfg.ctrl    = slv_reg[`BENCH_CTRL_REG][1:0];
  assign cfg.vaddr   = slv_reg[`BENCH_VADDR_REG][`BENCH_VADDR_BITS-1:0];
  assign cfg.len     = slv_reg[`BENCH_LEN_REG][`BENCH_LEN_BITS-1:0];
  assign cfg.pid     = slv_reg[`BENCH_PID_REG][`BENCH_PID_BITS-1:0];
  assign cfg.n_reps  = slv_reg[`BENCH_N_REPS_REG][31:0];
  assign cfg.n_beats = slv_reg[`BENCH_N_BEATS_REG];

  // ------------------------------
  // Register reads
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      case (rd_idx)
        `BENCH_DONE_REG:    rdata <= bench_pkg::axil_data_t'(cfg.done);
        `BENCH_TIMER_REG:   rdata <= cfg.timer;
        `BENCH_VADDR_REG:   rdata <= bench_pkg::axil_data_t'(cfg.vaddr);
        `BENCH_LEN_REG:     rdata <= bench_pkg::axil_data_t'(cfg.len);
        `BENCH_PID_REG:     rdata <= bench_pkg::axil_data_t'(cfg.pid);
        `BENCH_N_REPS_REG:  rdata <= bench_pkg::axil_data_t'(cfg.n_reps);
        `BENCH_N_BEATS_REG: rdata <= cfg.n_beats;
        default:            rdata <= '0;   // Control reads back as zero
      endcase
    end
  end

  // ------------------------------
  // Protocol checks
  // ------------------------------
  // A write response needs both aw and w accepted on the bus the cycle before
  a_bvalid_after_wr : assert property (
    @(posedge aclk) disable iff (!aresetn)
    $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready)
  ) else $error("bvalid rose without a write handshake");

  a_rdata_stable : assert property (
    @(posedge aclk) disable iff (!aresetn)
    rvalid && !rready |=> $stable(rdata)
  ) else $error("rdata changed while rvalid was held");

endmodule

`default_nettype wire

// File: verilog/bench_cfg_if.sv
/* Configuration and status bundle between register slave and engine */

`timescale 1ns/10ps
`default_nettype none

interface bench_cfg_if;

  // Set up by the host
  bench_pkg::bench_ctrl_t ctrl;    // One-cycle start pulse
  bench_pkg::vaddr_t      vaddr;
  bench_pkg::len_t        len;
  bench_pkg::pid_t        pid;
  bench_pkg::reps_t       n_reps;
  bench_pkg::beats_t      n_beats;

  // Returned by the engine
  bench_pkg::reps_t       done;
  bench_pkg::timer_t      timer;

  modport regs (
    output ctrl, vaddr, len, pid, n_reps, n_beats,
    input  done, timer
  );

  modport engine (
    input  ctrl, vaddr, len, pid, n_reps, n_beats,
    output done, timer
  );

endinterface

`default_nettype wire

// File: verilog/bench_pkg.sv
/* Vector types and engine state encoding shared by the benchmark block */

`default_nettype none

`include "bench_params.svh"

package bench_pkg;

  // ------------------------------
  // Control bus words
  // ------------------------------
  typedef logic [`BENCH_AXIL_DATA_BITS-1:0]   axil_data_t;
  typedef logic [`BENCH_AXIL_DATA_BITS/8-1:0] axil_strb_t;
  typedef logic [`BENCH_AXIL_ADDR_BITS-1:0]   axil_addr_t;

  // ------------------------------
  // Request and run fields
  // ------------------------------
  typedef logic [`BENCH_VADDR_BITS-1:0] vaddr_t;
  typedef logic [`BENCH_LEN_BITS-1:0]   len_t;    // Bytes per request
  typedef logic [`BENCH_PID_BITS-1:0]   pid_t;
  typedef logic [31:0]                  reps_t;   // Request and completion counts
  typedef logic [63:0]                  beats_t;
  typedef logic [63:0]                  timer_t;  // Cycles
  typedef logic [1:0]                   bench_ctrl_t;  // Bit 0 read run, bit 1 write run

  // Request engine states
  typedef enum logic [1:0] {
    ENG_IDLE,   // Waiting for start
    ENG_ISSUE,  // Handing out requests
    ENG_WAIT    // Draining completions and beats
  } eng_state_t;

endpackage

`default_nettype wire

// File: verilog/bench_params.svh
/* Bus widths, request field widths and register indices of the benchmark block */

`ifndef BENCH_PARAMS_SVH
`define BENCH_PARAMS_SVH

// ------------------------------
// AXI4-Lite control bus
// ------------------------------
`define BENCH_AXIL_DATA_BITS 64
`define BENCH_AXIL_ADDR_BITS 6   // 8 regs of 8 bytes
`define BENCH_N_REGS         8

// ------------------------------
// Request fields
// ------------------------------
`define BENCH_VADDR_BITS 48
`define BENCH_LEN_BITS   28
`define BENCH_PID_BITS   6

// Register map in 64-bit words
`define BENCH_CTRL_REG    0   // W1S start pulse
`define BENCH_DONE_REG    1   // RO completions
`define BENCH_TIMER_REG   2   // RO run cycles
`define BENCH_VADDR_REG   3
`define BENCH_LEN_REG     4
`define BENCH_PID_REG     5
`define BENCH_N_REPS_REG  6
`define BENCH_N_BEATS_REG 7   // Beats expected per run

`endif
